// File: design/axi_rd_if.sv
`timescale 1ns/1ns

interface axi_rd_if #(
    parameter int data_w = 64
);
    import xbar_pkg::*;

    // read address
    logic              arvalid;
    logic              arready;
    addr_t             araddr;
    id_t               arid;

    // read data
    logic              rvalid;
    logic              rready;
    resp_t             rresp;
    logic [data_w-1:0] rdata;
    id_t               rid;

    modport requester (
        output arvalid, araddr, arid, rready,
        input  arready, rvalid, rresp, rdata, rid
    );

    modport target (
        input  arvalid, araddr, arid, rready,
        output arready, rvalid, rresp, rdata, rid
    );

endinterface

// File: design/axi_wr_if.sv
`timescale 1ns/1ns

interface axi_wr_if #(
    parameter int data_w = 64
);
    import xbar_pkg::*;

    localparam int strb_w = data_w / 8;

    logic              awvalid;
    logic              awready;
    addr_t             awaddr;
    id_t               awid;

    logic              wvalid;
    logic              wready;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;

    logic              bvalid;
    logic              bready;
    resp_t             bresp;
    id_t               bid;

    modport requester (
        output awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
        input  awready, wready, bvalid, bresp, bid
    );

    modport target (
        input  awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
        output awready, wready, bvalid, bresp, bid
    );

endinterface

// File: design/bus_xbar.sv
`timescale 1ns/1ns

module bus_xbar #(
    parameter int data_w = 64,
    localparam int strb_w = data_w / 8
) (
    input  logic                clk,
    input  logic                rst,
    // fetch read port
    input  logic                if_arvalid, if_rready,
    input  xbar_pkg::addr_t     if_araddr,
    input  xbar_pkg::id_t       if_arid,
    output logic                if_arready, if_rvalid,
    output xbar_pkg::resp_t     if_rresp,
    output logic [data_w-1:0]   if_rdata,
    output xbar_pkg::id_t       if_rid,
    // load/store read port
    input  logic                mem_arvalid, mem_rready,
    input  xbar_pkg::addr_t     mem_araddr,
    input  xbar_pkg::id_t       mem_arid,
    output logic                mem_arready, mem_rvalid,
    output xbar_pkg::resp_t     mem_rresp,
    output logic [data_w-1:0]   mem_rdata,
    output xbar_pkg::id_t       mem_rid,
    // load/store write port
    input  logic                mem_awvalid, mem_wvalid, mem_bready,
    input  xbar_pkg::addr_t     mem_awaddr,
    input  xbar_pkg::id_t       mem_awid,
    input  logic [data_w-1:0]   mem_wdata,
    input  logic [strb_w-1:0]   mem_wstrb,
    output logic                mem_awready, mem_wready, mem_bvalid,
    output xbar_pkg::resp_t     mem_bresp,
    output xbar_pkg::id_t       mem_bid,
    // system bus
    output logic                io_arvalid, io_rready,
    output xbar_pkg::addr_t     io_araddr,
    output xbar_pkg::id_t       io_arid,
    input  logic                io_arready, io_rvalid,
    input  xbar_pkg::resp_t     io_rresp,
    input  logic [data_w-1:0]   io_rdata,
    input  xbar_pkg::id_t       io_rid,
    output logic                io_awvalid, io_wvalid, io_bready,
    output xbar_pkg::addr_t     io_awaddr,
    output xbar_pkg::id_t       io_awid,
    output logic [data_w-1:0]   io_wdata,
    output logic [strb_w-1:0]   io_wstrb,
    input  logic                io_awready, io_wready, io_bvalid,
    input  xbar_pkg::resp_t     io_bresp,
    input  xbar_pkg::id_t       io_bid,
    // timer block
    output logic                clint_arvalid, clint_rready,
    output xbar_pkg::addr_t     clint_araddr,
    output xbar_pkg::id_t       clint_arid,
    input  logic                clint_arready, clint_rvalid,
    input  xbar_pkg::resp_t     clint_rresp,
    input  logic [data_w-1:0]   clint_rdata,
    input  xbar_pkg::id_t       clint_rid,
    output logic                clint_awvalid, clint_wvalid, clint_bready,
    output xbar_pkg::addr_t     clint_awaddr,
    output xbar_pkg::id_t       clint_awid,
    output logic [data_w-1:0]   clint_wdata,
    output logic [strb_w-1:0]   clint_wstrb,
    input  logic                clint_awready, clint_wready, clint_bvalid,
    input  xbar_pkg::resp_t     clint_bresp,
    input  xbar_pkg::id_t       clint_bid
);

    axi_rd_if #(.data_w(data_w)) if_rd ();
    axi_rd_if #(.data_w(data_w)) mem_rd ();
    axi_rd_if #(.data_w(data_w)) io_rd ();
    axi_rd_if #(.data_w(data_w)) clint_rd ();
    axi_wr_if #(.data_w(data_w)) mem_wr ();
    axi_wr_if #(.data_w(data_w)) io_wr ();
    axi_wr_if #(.data_w(data_w)) clint_wr ();

    // requester side
    assign {if_rd.arvalid, if_rd.araddr, if_rd.arid, if_rd.rready} =
           {if_arvalid, if_araddr, if_arid, if_rready};
    assign {if_arready, if_rvalid, if_rresp, if_rdata, if_rid} =
           {if_rd.arready, if_rd.rvalid, if_rd.rresp, if_rd.rdata, if_rd.rid};
    assign {mem_rd.arvalid, mem_rd.araddr, mem_rd.arid, mem_rd.rready} =
           {mem_arvalid, mem_araddr, mem_arid, mem_rready};
    assign {mem_arready, mem_rvalid, mem_rresp, mem_rdata, mem_rid} =
           {mem_rd.arready, mem_rd.rvalid, mem_rd.rresp, mem_rd.rdata, mem_rd.rid};
    assign {mem_wr.awvalid, mem_wr.awaddr, mem_wr.awid, mem_wr.wvalid, mem_wr.wdata,
            mem_wr.wstrb, mem_wr.bready} =
           {mem_awvalid, mem_awaddr, mem_awid, mem_wvalid, mem_wdata, mem_wstrb, mem_bready};
    assign {mem_awready, mem_wready, mem_bvalid, mem_bresp, mem_bid} =
           {mem_wr.awready, mem_wr.wready, mem_wr.bvalid, mem_wr.bresp, mem_wr.bid};

    // target side
    assign {io_arvalid, io_araddr, io_arid, io_rready} =
           {io_rd.arvalid, io_rd.araddr, io_rd.arid, io_rd.rready};
    assign {io_rd.arready, io_rd.rvalid, io_rd.rresp, io_rd.rdata, io_rd.rid} =
           {io_arready, io_rvalid, io_rresp, io_rdata, io_rid};
    assign {clint_arvalid, clint_araddr, clint_arid, clint_rready} =
           {clint_rd.arvalid, clint_rd.araddr, clint_rd.arid, clint_rd.rready};
    assign {clint_rd.arready, clint_rd.rvalid, clint_rd.rresp, clint_rd.rdata, clint_rd.rid} =
           {clint_arready, clint_rvalid, clint_rresp, clint_rdata, clint_rid};
    assign {io_awvalid, io_awaddr, io_awid, io_wvalid, io_wdata, io_wstrb, io_bready} =
           {io_wr.awvalid, io_wr.awaddr, io_wr.awid, io_wr.wvalid, io_wr.wdata,
            io_wr.wstrb, io_wr.bready};
    assign {io_wr.awready, io_wr.wready, io_wr.bvalid, io_wr.bresp, io_wr.bid} =
           {io_awready, io_wready, io_bvalid, io_bresp, io_bid};
    assign {clint_awvalid, clint_awaddr, clint_awid, clint_wvalid, clint_wdata,
            clint_wstrb, clint_bready} =
           {clint_wr.awvalid, clint_wr.awaddr, clint_wr.awid, clint_wr.wvalid,
            clint_wr.wdata, clint_wr.wstrb, clint_wr.bready};
    assign {clint_wr.awready, clint_wr.wready, clint_wr.bvalid, clint_wr.bresp, clint_wr.bid} =
           {clint_awready, clint_wready, clint_bvalid, clint_bresp, clint_bid};

    read_arbiter #(.data_w(data_w)) u_read (
        .clk      (clk),
        .rst      (rst),
        .if_rd    (if_rd),
        .mem_rd   (mem_rd),
        .io_rd    (io_rd),
        .clint_rd (clint_rd)
    );

    write_router #(.data_w(data_w)) u_write (
        .clk      (clk),
        .rst      (rst),
        .mem_wr   (mem_wr),
        .io_wr    (io_wr),
        .clint_wr (clint_wr)
    );

endmodule

// File: design/read_arbiter.sv
`timescale 1ns/1ns

module read_arbiter #(
    parameter int data_w = 64
) (
    input  logic        clk,
    input  logic        rst,
    axi_rd_if.target    if_rd,
    axi_rd_if.target    mem_rd,
    axi_rd_if.requester io_rd,
    axi_rd_if.requester clint_rd
);
    import xbar_pkg::*;

    localparam logic [1:0] st_idle      = 2'd0;
    localparam logic [1:0] st_if_io     = 2'd1;
    localparam logic [1:0] st_mem_io    = 2'd2;
    localparam logic [1:0] st_mem_clint = 2'd3;

    logic [1:0]        state;
    logic              idle;
    logic              mem_to_clint;
    logic              r_done;
    logic [data_w-1:0] mem_rdata;

    assign idle = (state == st_idle);
    assign mem_to_clint = is_clint(mem_rd.araddr);

    // io address channel, fetch first
    always_comb begin
        io_rd.araddr = mem_rd.araddr;
        io_rd.arid = mem_rd.arid;
        io_rd.arvalid = idle && mem_rd.arvalid && !mem_to_clint;
        if (if_rd.arvalid) begin
            io_rd.araddr = if_rd.araddr;
            io_rd.arid = if_rd.arid;
            io_rd.arvalid = idle;
        end
    end

    // any fetch request holds mem off, clint included
    assign clint_rd.arvalid = idle && mem_rd.arvalid && mem_to_clint && !if_rd.arvalid;
    assign clint_rd.araddr = mem_rd.araddr;
    assign clint_rd.arid = mem_rd.arid;

    assign if_rd.arready = idle && io_rd.arready;
    assign mem_rd.arready = idle && !if_rd.arvalid &&
                            (mem_to_clint ? clint_rd.arready : io_rd.arready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (if_rd.arvalid && if_rd.arready) begin
                        state <= st_if_io;
                    end else if (mem_rd.arvalid && mem_rd.arready) begin
                        state <= mem_to_clint ? st_mem_clint : st_mem_io;
                    end
                end
                default: begin
                    if (r_done) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // release on the first accepted beat with our id
    always_comb begin
        case (state)
            st_if_io:     r_done = io_rd.rvalid && io_rd.rready && (io_rd.rid == if_id);
            st_mem_io:    r_done = io_rd.rvalid && io_rd.rready && (io_rd.rid == mem_id);
            st_mem_clint: r_done = clint_rd.rvalid && clint_rd.rready &&
                                   (clint_rd.rid == mem_id);
            default:      r_done = 1'b0;
        endcase
    end

    assign io_rd.rready = (state == st_if_io) ? if_rd.rready :
                          (state == st_mem_io) && mem_rd.rready;
    assign clint_rd.rready = (state == st_mem_clint) && mem_rd.rready;

    // fetch only ever reads from io
    assign if_rd.rvalid = (state == st_if_io) && io_rd.rvalid;
    assign if_rd.rresp = io_rd.rresp;
    assign if_rd.rdata = io_rd.rdata;
    assign if_rd.rid = io_rd.rid;

    always_comb begin
        mem_rd.rvalid = (state == st_mem_io) && io_rd.rvalid;
        mem_rd.rresp = io_rd.rresp;
        mem_rd.rid = io_rd.rid;
        mem_rdata = io_rd.rdata;
        if (state == st_mem_clint) begin
            mem_rd.rvalid = clint_rd.rvalid;
            mem_rd.rresp = clint_rd.rresp;
            mem_rd.rid = clint_rd.rid;
            mem_rdata = clint_rd.rdata;
        end
    end

    assign mem_rd.rdata = mem_rdata;

endmodule

// File: design/write_router.sv
`timescale 1ns/1ns

module write_router #(
    parameter int data_w = 64
) (
    input  logic        clk,
    input  logic        rst,
    axi_wr_if.target    mem_wr,
    axi_wr_if.requester io_wr,
    axi_wr_if.requester clint_wr
);
    import xbar_pkg::*;

    localparam int strb_w = data_w / 8;

    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_w_io    = 2'd1;
    localparam logic [1:0] st_w_clint = 2'd2;

    logic [1:0] state;
    logic       idle;
    logic       to_clint;
    logic       b_done;

    // one strobe bit per data byte
    if (strb_w * 8 != data_w) begin : g_width_check
        $error("write_router: data_w must be a whole number of bytes");
    end

    assign idle = (state == st_idle);
    assign to_clint = is_clint(mem_wr.awaddr);

    assign io_wr.awvalid = idle && mem_wr.awvalid && !to_clint;
    assign clint_wr.awvalid = idle && mem_wr.awvalid && to_clint;
    assign mem_wr.awready = idle && (to_clint ? clint_wr.awready : io_wr.awready);

    assign io_wr.awaddr = mem_wr.awaddr;
    assign io_wr.awid = mem_wr.awid;
    assign clint_wr.awaddr = mem_wr.awaddr;
    assign clint_wr.awid = mem_wr.awid;

    // w beat only toward the routed target
    assign io_wr.wvalid = (state == st_w_io) && mem_wr.wvalid;
    assign clint_wr.wvalid = (state == st_w_clint) && mem_wr.wvalid;
    assign io_wr.wdata = mem_wr.wdata;
    assign io_wr.wstrb = mem_wr.wstrb;
    assign clint_wr.wdata = mem_wr.wdata;
    assign clint_wr.wstrb = mem_wr.wstrb;
    assign io_wr.bready = mem_wr.bready;
    assign clint_wr.bready = mem_wr.bready;

    always_comb begin
        case (state)
            st_w_io: begin
                mem_wr.wready = io_wr.wready;
                mem_wr.bvalid = io_wr.bvalid;
                mem_wr.bresp = io_wr.bresp;
                mem_wr.bid = io_wr.bid;
            end
            st_w_clint: begin
                mem_wr.wready = clint_wr.wready;
                mem_wr.bvalid = clint_wr.bvalid;
                mem_wr.bresp = clint_wr.bresp;
                mem_wr.bid = clint_wr.bid;
            end
            default: begin
                mem_wr.wready = 1'b0;
                mem_wr.bvalid = 1'b0;
                mem_wr.bresp = io_wr.bresp;
                mem_wr.bid = io_wr.bid;
            end
        endcase
    end

    assign b_done = mem_wr.bvalid && mem_wr.bready && (mem_wr.bid == mem_id);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else if (idle) begin
            if (mem_wr.awvalid && mem_wr.awready) begin
                state <= to_clint ? st_w_clint : st_w_io;
            end
        end else if (b_done) begin
            state <= st_idle;
        end
    end

endmodule

// File: design/xbar_pkg.sv
package xbar_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [3:0]  id_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_exokay = 2'b01;
    localparam resp_t resp_slverr = 2'b10;
    localparam resp_t resp_decerr = 2'b11;

    // requester ids
    localparam id_t if_id  = 4'd0;
    localparam id_t mem_id = 4'd1;

    // mtime register pair
    localparam addr_t clint_mtime_lo = 32'h0200_bff8;
    localparam addr_t clint_mtime_hi = 32'h0200_bfff;

    // mtimecmp register pair
    localparam addr_t clint_cmp_lo = 32'h0200_4000;
    localparam addr_t clint_cmp_hi = 32'h0200_4007;

    function automatic logic is_clint(input addr_t addr);
        logic in_mtime;
        logic in_cmp;
        in_mtime = (addr >= clint_mtime_lo) && (addr <= clint_mtime_hi);
        in_cmp = (addr >= clint_cmp_lo) && (addr <= clint_cmp_hi);
        return in_mtime || in_cmp;
    endfunction

endpackage

// File: list.f
design/xbar_pkg.sv
design/axi_rd_if.sv
design/axi_wr_if.sv
design/read_arbiter.sv
design/write_router.sv
design/bus_xbar.sv
tb/xbar_properties.sv
tb/tb_bus_xbar.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_bus_xbar -f list.f

out=$(./obj_dir/Vtb_bus_xbar) || true
echo "$out"
echo "$out" | grep -qx "Everything OK"

// File: tb/tb_bus_xbar.sv
`timescale 1ns/1ns

module tb_bus_xbar;
    import xbar_pkg::*;

    localparam int data_w = 64;
    localparam int strb_w = data_w / 8;
    localparam int n_reads = 60;
    localparam int n_writes = 60;
    localparam int max_wait = 500;

    logic clk;
    logic rst;

    // requester side, index 0 is fetch and 1 is load/store, so index equals id
    logic              rq_arvalid [2], rq_rready [2], rq_arready [2], rq_rvalid [2];
    addr_t             rq_araddr [2];
    id_t               rq_arid [2], rq_rid [2];
    resp_t             rq_rresp [2];
    logic [data_w-1:0] rq_rdata [2];

    // target side, index 0 is io and 1 is clint
    logic              tg_arvalid [2], tg_rready [2], tg_arready [2], tg_rvalid [2];
    addr_t             tg_araddr [2], tg_awaddr [2];
    id_t               tg_arid [2], tg_rid [2], tg_awid [2], tg_bid [2];
    resp_t             tg_rresp [2], tg_bresp [2];
    logic [data_w-1:0] tg_rdata [2], tg_wdata [2];
    logic [strb_w-1:0] tg_wstrb [2];
    logic              tg_awvalid [2], tg_wvalid [2], tg_bready [2];
    logic              tg_awready [2], tg_wready [2], tg_bvalid [2];

    // load/store write port
    logic              awvalid, wvalid, bready, awready, wready, bvalid;
    addr_t             awaddr;
    id_t               awid, bid;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    resp_t             bresp;

    // reference model queues
    logic [35:0]  exp_ar_q [2][$];
    logic [65:0]  exp_r_q [2][$];
    logic [103:0] exp_aw_q [2][$];
    resp_t        exp_b_q [$];

    logic [31:0] lfsr = 32'h44b9_b42e;

    bus_xbar #(.data_w(data_w)) dut0 (
        .clk(clk), .rst(rst),
        .if_arvalid(rq_arvalid[0]), .if_rready(rq_rready[0]), .if_araddr(rq_araddr[0]),
        .if_arid(rq_arid[0]), .if_arready(rq_arready[0]), .if_rvalid(rq_rvalid[0]),
        .if_rresp(rq_rresp[0]), .if_rdata(rq_rdata[0]), .if_rid(rq_rid[0]),
        .mem_arvalid(rq_arvalid[1]), .mem_rready(rq_rready[1]), .mem_araddr(rq_araddr[1]),
        .mem_arid(rq_arid[1]), .mem_arready(rq_arready[1]), .mem_rvalid(rq_rvalid[1]),
        .mem_rresp(rq_rresp[1]), .mem_rdata(rq_rdata[1]), .mem_rid(rq_rid[1]),
        .mem_awvalid(awvalid), .mem_wvalid(wvalid), .mem_bready(bready),
        .mem_awaddr(awaddr), .mem_awid(awid), .mem_wdata(wdata), .mem_wstrb(wstrb),
        .mem_awready(awready), .mem_wready(wready), .mem_bvalid(bvalid),
        .mem_bresp(bresp), .mem_bid(bid),
        .io_arvalid(tg_arvalid[0]), .io_rready(tg_rready[0]), .io_araddr(tg_araddr[0]),
        .io_arid(tg_arid[0]), .io_arready(tg_arready[0]), .io_rvalid(tg_rvalid[0]),
        .io_rresp(tg_rresp[0]), .io_rdata(tg_rdata[0]), .io_rid(tg_rid[0]),
        .io_awvalid(tg_awvalid[0]), .io_wvalid(tg_wvalid[0]), .io_bready(tg_bready[0]),
        .io_awaddr(tg_awaddr[0]), .io_awid(tg_awid[0]), .io_wdata(tg_wdata[0]),
        .io_wstrb(tg_wstrb[0]), .io_awready(tg_awready[0]), .io_wready(tg_wready[0]),
        .io_bvalid(tg_bvalid[0]), .io_bresp(tg_bresp[0]), .io_bid(tg_bid[0]),
        .clint_arvalid(tg_arvalid[1]), .clint_rready(tg_rready[1]),
        .clint_araddr(tg_araddr[1]), .clint_arid(tg_arid[1]),
        .clint_arready(tg_arready[1]), .clint_rvalid(tg_rvalid[1]),
        .clint_rresp(tg_rresp[1]), .clint_rdata(tg_rdata[1]), .clint_rid(tg_rid[1]),
        .clint_awvalid(tg_awvalid[1]), .clint_wvalid(tg_wvalid[1]),
        .clint_bready(tg_bready[1]), .clint_awaddr(tg_awaddr[1]),
        .clint_awid(tg_awid[1]), .clint_wdata(tg_wdata[1]), .clint_wstrb(tg_wstrb[1]),
        .clint_awready(tg_awready[1]), .clint_wready(tg_wready[1]),
        .clint_bvalid(tg_bvalid[1]), .clint_bresp(tg_bresp[1]), .clint_bid(tg_bid[1])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic coin();
        logic [31:0] v;
        v = rand_bits(1);
        return v[0];
    endfunction

    // roughly one address in four lands in a clint window
    function automatic addr_t rand_addr();
        addr_t a;
        a = rand_bits(32);
        if (rand_bits(2) == 0) begin
            a = coin() ? clint_mtime_lo : clint_cmp_lo;
            a = a + rand_bits(3);
        end
        return a;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
            abort_run("value mismatch");
        end
    endtask

    task automatic read_requester(input int r);
        int          n;
        int          wt;
        int          tgt;
        addr_t       a;
        logic [65:0] got;
        for (n = 0; n < n_reads; n++) begin
            // first request of both requesters lands in the same cycle
            if (n > 0) begin
                repeat (rand_bits(3)) step();
            end
            a = rand_addr();
            rq_arvalid[r] = 1'b1;
            rq_araddr[r] = a;
            rq_arid[r] = id_t'(r);
            wt = 0;
            @(negedge clk);
            while (!rq_arready[r]) begin
                if (++wt > max_wait) abort_run($sformatf("timeout on arready, requester %0d", r));
                step();
                @(negedge clk);
            end
            tgt = (r == 1 && is_clint(a)) ? 1 : 0;
            exp_ar_q[tgt].push_back({id_t'(r), a});
            step();
            rq_arvalid[r] = 1'b0;
            wt = 0;
            rq_rready[r] = coin();
            @(negedge clk);
            while (!(rq_rvalid[r] && rq_rready[r])) begin
                if (++wt > max_wait) abort_run($sformatf("timeout on read data, requester %0d", r));
                step();
                rq_rready[r] = coin();
                @(negedge clk);
            end
            if (exp_r_q[r].size() == 0) abort_run("read data arrived that no target supplied");
            got = exp_r_q[r].pop_front();
            check("read rdata", got[63:0], rq_rdata[r]);
            check("read rresp", got[65:64], rq_rresp[r]);
            check("read rid", r, rq_rid[r]);
            step();
            rq_rready[r] = 1'b0;
        end
    endtask

    task automatic read_target(input int t);
        logic [35:0] ex;
        logic [65:0] sup;
        addr_t       a;
        id_t         id;
        int          wt;
        forever begin
            tg_arready[t] = coin();
            @(negedge clk);
            if (tg_arvalid[t] && tg_arready[t]) begin
                a = tg_araddr[t];
                id = tg_arid[t];
                step();
                tg_arready[t] = 1'b0;
                if (exp_ar_q[t].size() == 0) abort_run("read request reached the wrong target");
                ex = exp_ar_q[t].pop_front();
                check("ar address", ex[31:0], a);
                check("ar id", ex[35:32], id);
                repeat (rand_bits(3)) step();
                sup = {resp_t'(rand_bits(2)), rand_bits(32), rand_bits(32)};
                exp_r_q[id].push_back(sup);
                tg_rvalid[t] = 1'b1;
                tg_rresp[t] = sup[65:64];
                tg_rdata[t] = sup[63:0];
                tg_rid[t] = id;
                wt = 0;
                @(negedge clk);
                while (!tg_rready[t]) begin
                    if (++wt > max_wait) abort_run($sformatf("timeout on rready, target %0d", t));
                    step();
                    @(negedge clk);
                end
                step();
                tg_rvalid[t] = 1'b0;
            end else begin
                step();
            end
        end
    endtask

    task automatic write_requester();
        int                n;
        int                wt;
        addr_t             a;
        logic [data_w-1:0] d;
        logic [strb_w-1:0] s;
        resp_t             ex;
        for (n = 0; n < n_writes; n++) begin
            repeat (rand_bits(3)) step();
            a = rand_addr();
            d = {rand_bits(32), rand_bits(32)};
            s = strb_w'(rand_bits(strb_w));
            awvalid = 1'b1;
            awaddr = a;
            awid = mem_id;
            wt = 0;
            @(negedge clk);
            while (!awready) begin
                if (++wt > max_wait) abort_run("timeout on awready");
                step();
                @(negedge clk);
            end
            exp_aw_q[is_clint(a) ? 1 : 0].push_back({a, s, d});
            step();
            awvalid = 1'b0;
            wvalid = 1'b1;
            wdata = d;
            wstrb = s;
            wt = 0;
            @(negedge clk);
            while (!wready) begin
                if (++wt > max_wait) abort_run("timeout on wready");
                step();
                @(negedge clk);
            end
            step();
            wvalid = 1'b0;
            wt = 0;
            bready = coin();
            @(negedge clk);
            while (!(bvalid && bready)) begin
                if (++wt > max_wait) abort_run("timeout on write response");
                step();
                bready = coin();
                @(negedge clk);
            end
            if (exp_b_q.size() == 0) abort_run("write response arrived that no target sent");
            ex = exp_b_q.pop_front();
            check("write bresp", ex, bresp);
            check("write bid", mem_id, bid);
            step();
            bready = 1'b0;
        end
    endtask

    task automatic write_target(input int t);
        logic [103:0] ex;
        addr_t        a;
        id_t          id;
        resp_t        rs;
        int           wt;
        forever begin
            tg_awready[t] = coin();
            @(negedge clk);
            if (tg_awvalid[t] && tg_awready[t]) begin
                a = tg_awaddr[t];
                id = tg_awid[t];
                step();
                tg_awready[t] = 1'b0;
                wt = 0;
                tg_wready[t] = coin();
                @(negedge clk);
                while (!(tg_wvalid[t] && tg_wready[t])) begin
                    if (++wt > max_wait) abort_run($sformatf("timeout on wvalid, target %0d", t));
                    step();
                    tg_wready[t] = coin();
                    @(negedge clk);
                end
                if (exp_aw_q[t].size() == 0) abort_run("write reached the wrong target");
                ex = exp_aw_q[t].pop_front();
                check("aw address", ex[103:72], a);
                check("aw id", mem_id, id);
                check("w strobe", ex[71:64], tg_wstrb[t]);
                check("w data", ex[63:0], tg_wdata[t]);
                step();
                tg_wready[t] = 1'b0;
                repeat (rand_bits(3)) step();
                rs = resp_t'(rand_bits(2));
                exp_b_q.push_back(rs);
                tg_bvalid[t] = 1'b1;
                tg_bresp[t] = rs;
                tg_bid[t] = id;
                wt = 0;
                @(negedge clk);
                while (!tg_bready[t]) begin
                    if (++wt > max_wait) abort_run($sformatf("timeout on bready, target %0d", t));
                    step();
                    @(negedge clk);
                end
                step();
                tg_bvalid[t] = 1'b0;
            end else begin
                step();
            end
        end
    endtask

    // grant ownership seen from the requester side
    task automatic watch_reads();
        int owner;
        int i;
        owner = -1;
        forever begin
            @(negedge clk);
            if (rq_arvalid[0] && rq_arready[1]) begin
                abort_run("load/store read accepted while fetch was requesting");
            end
            for (i = 0; i < 2; i++) begin
                if (rq_rvalid[i] && owner != i) begin
                    abort_run($sformatf("read data reached requester %0d without a grant", i));
                end
                if (rq_arvalid[i] && rq_arready[i]) begin
                    if (owner != -1) abort_run("read accepted while a grant was held");
                    owner = i;
                end else if (rq_rvalid[i] && rq_rready[i] && rq_rid[i] == id_t'(i)) begin
                    owner = -1;
                end
            end
        end
    endtask

    initial begin
        rq_arvalid = '{default: 1'b0};
        rq_araddr = '{default: '0};
        rq_arid = '{default: '0};
        rq_rready = '{default: 1'b0};
        tg_arready = '{default: 1'b0};
        tg_rvalid = '{default: 1'b0};
        tg_rresp = '{default: '0};
        tg_rdata = '{default: '0};
        tg_rid = '{default: '0};
        tg_awready = '{default: 1'b0};
        tg_wready = '{default: 1'b0};
        tg_bvalid = '{default: 1'b0};
        tg_bresp = '{default: '0};
        tg_bid = '{default: '0};
        awvalid = 1'b0;
        awaddr = '0;
        awid = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            read_target(0);
            read_target(1);
            write_target(0);
            write_target(1);
            watch_reads();
        join_none
        fork
            read_requester(0);
            read_requester(1);
            write_requester();
        join
        repeat (4) step();
        check("open read requests", 0, exp_ar_q[0].size() + exp_ar_q[1].size());
        check("unclaimed read data", 0, exp_r_q[0].size() + exp_r_q[1].size());
        check("open writes", 0, exp_aw_q[0].size() + exp_aw_q[1].size() + exp_b_q.size());
        $display("Everything OK");
        $finish;
    end

endmodule

// File: tb/xbar_properties.sv
`timescale 1ns/1ns

// one instance per path, read and write
module xbar_properties (
    input logic clk,
    input logic rst,
    input logic io_valid,
    input logic clint_valid,
    input logic req_ready_a,
    input logic req_ready_b,
    input logic held
);

    // a request is steered to one target at most
    one_target: assert property (@(posedge clk) disable iff (rst)
        !(io_valid && clint_valid))
        else $error("request presented to io and clint in the same cycle");

    // no address phase is accepted while the grant or route is held
    no_accept_while_held: assert property (@(posedge clk) disable iff (rst)
        held |-> !(req_ready_a || req_ready_b))
        else $error("address phase accepted while busy");

endmodule

bind read_arbiter xbar_properties rd_props (
    .clk         (clk),
    .rst         (rst),
    .io_valid    (io_rd.arvalid),
    .clint_valid (clint_rd.arvalid),
    .req_ready_a (if_rd.arready),
    .req_ready_b (mem_rd.arready),
    .held        (!idle)
);

bind write_router xbar_properties wr_props (
    .clk         (clk),
    .rst         (rst),
    .io_valid    (io_wr.awvalid),
    .clint_valid (clint_wr.awvalid),
    .req_ready_a (mem_wr.awready),
    .req_ready_b (1'b0),
    .held        (!idle)
);
